//--- common/cache_pkg.sv
// data cache geometry and the cache and memory side request structs, shared by cache and RAM
`default_nettype none

package cache_pkg;

    import pipe_pkg::*;

    // 16 lines of 4 words
    localparam int IDX_W   = 4;
    localparam int OFS_W   = 2;
    // word address width, byte offset dropped
    localparam int WADDR_W = 30;
    localparam int TAG_W   = WADDR_W - IDX_W - OFS_W;

    // split view of a word address
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFS_W-1:0] ofs;
    } addr_fields_t;

    // same word, flat for the stage and split for the cache
    typedef union packed {
        logic [WADDR_W-1:0] flat;
        addr_fields_t       f;
    } word_addr_u;

    // stage to cache, one word access
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_addr_u addr;
        word_t      wdata;
    } dc_req_t;

    // cache to backing memory, four-phase req/ack
    typedef struct packed {
        logic               req;
        logic               we;
        logic [WADDR_W-1:0] addr;
        word_t              wdata;
    } ram_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } ram_rsp_t;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
// pipeline stage bundles, imported by the memory stage, the top level and the testbench
`default_nettype none

package pipe_pkg;

    // datapath word, also the default data width of the stage
    typedef logic [31:0] word_t;

    // EX/MEM register contents as presented by the execute side
    typedef struct packed {
        logic       valid;
        // byte address for loads and stores
        word_t      alu_result;
        // store data
        word_t      second_opr;
        word_t      nx_pc;
        logic       memrd;
        logic       memwr;
        // destination register, passed through to writeback
        logic [4:0] rd;
        logic       mem2reg;
        logic       regwr;
    } ex_mem_t;

    // MEM/WB register contents seen by writeback
    typedef struct packed {
        logic       valid;
        word_t      nx_pc;
        word_t      alu_result;
        // load data, zero for non-load bundles
        word_t      mem_dat;
        logic [4:0] rd;
        logic       mem2reg;
        logic       regwr;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- dcache/dcache.sv
// direct-mapped write-through data cache, refills a 4-word line from the backing RAM on a read miss
`timescale 1ns/10ps
`default_nettype none

module dcache
    import pipe_pkg::*;
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  dc_req_t  dc_req,
    output word_t    dc_rdata,
    output logic     dc_stall,
    output ram_req_t ram_req,
    input  ram_rsp_t ram_rsp
);

    localparam int LINES      = 1 << IDX_W;
    localparam int LINE_WORDS = 1 << OFS_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REFILL,
        S_FILL,
        S_WRITE
    } state_t;

    state_t           state_q;
    // handshake state toward the RAM
    logic             req_q;
    // ack seen and req dropped, waiting for ack to fall
    logic             hs_wait_q;
    // refill word counter
    logic [OFS_W-1:0] cnt_q;
    // access latched while the RAM is busy
    word_addr_u       lat_addr_q;
    word_t            lat_wdata_q;

    logic [TAG_W-1:0] tag_arr  [LINES];
    logic [LINES-1:0] valid_q;
    word_t            data_arr [LINES][LINE_WORDS];

    logic             hit;
    logic             ack_seen;
    logic             hs_done;

    // tag compare on the split view of the request
    assign hit = valid_q[dc_req.addr.f.idx] &&
                 (tag_arr[dc_req.addr.f.idx] == dc_req.addr.f.tag);
    assign ack_seen = req_q && ram_rsp.ack;
    assign hs_done  = hs_wait_q && !ram_rsp.ack;

    // read port always looks at the current request
    assign dc_rdata = data_arr[dc_req.addr.f.idx][dc_req.addr.f.ofs];

    always_comb begin
        case (state_q)
            S_IDLE:  dc_stall = (dc_req.ren && !hit) || dc_req.wen;
            // released in the cycle that ack is seen low
            S_WRITE: dc_stall = !hs_done;
            default: dc_stall = 1'b1;
        endcase
    end

    always_comb begin
        ram_req.req   = req_q;
        ram_req.we    = (state_q == S_WRITE);
        ram_req.wdata = lat_wdata_q;
        // refill walks the line, write uses the latched word
        if (state_q == S_REFILL) begin
            ram_req.addr = {lat_addr_q.f.tag, lat_addr_q.f.idx, cnt_q};
        end else begin
            ram_req.addr = lat_addr_q.flat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            req_q     <= 1'b0;
            hs_wait_q <= 1'b0;
            cnt_q     <= '0;
            valid_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (dc_req.wen) begin
                        state_q <= S_WRITE;
                        req_q   <= 1'b1;
                    end else if (dc_req.ren && !hit) begin
                        // line gets overwritten, drop it now
                        state_q                     <= S_REFILL;
                        req_q                       <= 1'b1;
                        cnt_q                       <= '0;
                        valid_q[dc_req.addr.f.idx] <= 1'b0;
                    end
                end
                S_REFILL: begin
                    if (ack_seen) begin
                        req_q     <= 1'b0;
                        hs_wait_q <= 1'b1;
                    end else if (hs_done) begin
                        hs_wait_q <= 1'b0;
                        if (cnt_q == '1) begin
                            state_q <= S_FILL;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                            req_q <= 1'b1;
                        end
                    end
                end
                S_FILL: begin
                    // whole line in, mark it usable
                    valid_q[lat_addr_q.f.idx] <= 1'b1;
                    state_q                   <= S_IDLE;
                end
                S_WRITE: begin
                    if (ack_seen) begin
                        req_q     <= 1'b0;
                        hs_wait_q <= 1'b1;
                    end else if (hs_done) begin
                        hs_wait_q <= 1'b0;
                        state_q   <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // arrays and latched access
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE) begin
            lat_addr_q  <= dc_req.addr;
            lat_wdata_q <= dc_req.wdata;
        end
        // write hit keeps the line coherent with memory
        if (state_q == S_IDLE && dc_req.wen && hit) begin
            data_arr[dc_req.addr.f.idx][dc_req.addr.f.ofs] <= dc_req.wdata;
        end
        if (state_q == S_REFILL && ack_seen) begin
            data_arr[lat_addr_q.f.idx][cnt_q] <= ram_rsp.rdata;
        end
        if (state_q == S_FILL) begin
            tag_arr[lat_addr_q.f.idx] <= lat_addr_q.f.tag;
        end
    end

    // a new req waits until the RAM has dropped the previous ack
    a_req_after_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ram_req.req) |-> !ram_rsp.ack
    );

endmodule

`default_nettype wire

//--- mem_stage/mem_stage.sv
// memory stage of the pipeline, turns the EX/MEM bundle into cache accesses and the MEM/WB bundle
`timescale 1ns/10ps
`default_nettype none

module mem_stage
    import pipe_pkg::*;
    import cache_pkg::*;
#(
    parameter int BIT_W = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output dc_req_t dc_req,
    input  word_t   dc_rdata,
    input  logic    dc_stall
);

    // control half of MEM/WB
    logic       wb_valid_q;
    logic       wb_mem2reg_q;
    logic       wb_regwr_q;
    // payload half of MEM/WB
    word_t      wb_nx_pc_q;
    word_t      wb_alu_q;
    word_t      wb_mem_dat_q;
    logic [4:0] wb_rd_q;
    // data picked up by a load
    word_t      ld_dat;

    // requests only for a valid bundle
    always_comb begin
        dc_req.ren       = ex_mem.valid && ex_mem.memrd;
        dc_req.wen       = ex_mem.valid && ex_mem.memwr;
        // drop the byte offset, word accesses only
        dc_req.addr.flat = ex_mem.alu_result[BIT_W-1:2];
        dc_req.wdata     = ex_mem.second_opr;
    end

    assign ld_dat = ex_mem.memrd ? dc_rdata : '0;

    // a stall turns the register into a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q   <= 1'b0;
            wb_mem2reg_q <= 1'b0;
            wb_regwr_q   <= 1'b0;
        end else if (dc_stall) begin
            wb_valid_q   <= 1'b0;
            wb_mem2reg_q <= 1'b0;
            wb_regwr_q   <= 1'b0;
        end else begin
            wb_valid_q   <= ex_mem.valid;
            wb_mem2reg_q <= ex_mem.valid && ex_mem.mem2reg;
            wb_regwr_q   <= ex_mem.valid && ex_mem.regwr;
        end
    end

    // payload only moves when the cache lets the bundle through
    always_ff @(posedge clk) begin
        if (!dc_stall) begin
            wb_nx_pc_q   <= ex_mem.nx_pc;
            wb_alu_q     <= ex_mem.alu_result;
            wb_mem_dat_q <= ld_dat;
            wb_rd_q      <= ex_mem.rd;
        end
    end

    always_comb begin
        mem_wb.valid      = wb_valid_q;
        mem_wb.nx_pc      = wb_nx_pc_q;
        mem_wb.alu_result = wb_alu_q;
        mem_wb.mem_dat    = wb_mem_dat_q;
        mem_wb.rd         = wb_rd_q;
        mem_wb.mem2reg    = wb_mem2reg_q;
        mem_wb.regwr      = wb_regwr_q;
    end

    // decode never marks one instruction as both load and store
    a_rd_wr_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_mem.valid |-> !(ex_mem.memrd && ex_mem.memwr)
    );

endmodule

`default_nettype wire

//--- mem_subsys.f
common/pipe_pkg.sv
common/cache_pkg.sv
mem_stage/mem_stage.sv
dcache/dcache.sv
verilog/data_ram.sv
verilog/mem_subsys.sv
verif/mem_subsys_tb.sv

//--- verif/mem_input.txt
# op  byte_addr  store_data  rd  load_data
# op is none, load or store; all values hex except rd in decimal
none  00000040 00000000 1 00000000
load  00000010 00000000 2 00000004
store 00000014 cafe0001 0 00000000
load  00000014 00000000 3 cafe0001
load  00000110 00000000 4 00000044
load  00000018 00000000 5 00000006
load  00000114 00000000 6 00000045
store 00000200 beef0002 0 00000000
load  00000200 00000000 7 beef0002
load  00000014 00000000 8 cafe0001
none  00000abc 00000000 9 00000000

//--- verif/mem_subsys_tb.sv
// testbench for the memory subsystem, replays the vectors in verif/mem_input.txt and checks MEM/WB
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb
    import pipe_pkg::*;
    import cache_pkg::*;
();

    localparam int RST_CYCLES  = 5;
    localparam int CYC_PER_VEC = 20;
    localparam int MODEL_WORDS = 256;
    localparam int LINES       = 1 << IDX_W;

    logic    clk;
    logic    rst_n;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    stall;

    // vectors as read from the file
    string      vec_op[$];
    word_t      vec_addr[$];
    word_t      vec_wdata[$];
    logic [4:0] vec_rd[$];
    word_t      vec_exp[$];

    // reference memory and the tags the cache should hold
    word_t            model_mem[MODEL_WORDS];
    logic             line_valid[LINES];
    logic [TAG_W-1:0] line_tag[LINES];

    int cycle_cnt   = 0;
    int cycle_limit = 0;

    mem_subsys #(
        .BIT_W (32)
    ) i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .stall  (stall)
    );

    always #10 clk = ~clk;

    // run limit, armed once the vector count is known
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("run hung, no completion after %0d cycles", cycle_cnt);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic string fmt_wb(input mem_wb_t w);
        return $sformatf("valid=%0b nx_pc=%h alu=%h dat=%h rd=%0d m2r=%0b rw=%0b",
                         w.valid, w.nx_pc, w.alu_result, w.mem_dat, w.rd, w.mem2reg, w.regwr);
    endfunction

    task automatic check_wb(input string name, input mem_wb_t exp, input mem_wb_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected {%s} got {%s}",
                                    $time, name, fmt_wb(exp), fmt_wb(act)));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    n;
        int    r;
        string tok;
        string rest;
        word_t a;
        word_t d;
        word_t e;
        fd = $fopen("verif/mem_input.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open verif/mem_input.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                break;
            end
            if (tok[0] == "#") begin
                // comment, drop the rest of the line
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %d %h", a, d, r, e);
                if (n != 4 || !(tok == "none" || tok == "load" || tok == "store")) begin
                    stop_on_error($sformatf("malformed vector line starting with '%s'", tok));
                end
                vec_op.push_back(tok);
                vec_addr.push_back(a);
                vec_wdata.push_back(d);
                vec_rd.push_back(r[4:0]);
                vec_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        ex_mem_t          b;
        mem_wb_t          exp_wb;
        word_t            waddr;
        word_t            exp_dat;
        logic             is_ld;
        logic             is_st;
        logic             exp_stall;
        logic             saw_stall;
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        int               midx;
        is_ld = (vec_op[i] == "load");
        is_st = (vec_op[i] == "store");
        // word address split into line index and tag
        waddr = vec_addr[i] >> 2;
        idx   = waddr[OFS_W +: IDX_W];
        tag   = TAG_W'(waddr >> (OFS_W + IDX_W));
        midx  = waddr % MODEL_WORDS;
        exp_dat   = '0;
        exp_stall = 1'b0;
        if (is_st) begin
            // write-through always waits on memory, no allocate
            exp_stall       = 1'b1;
            model_mem[midx] = vec_wdata[i];
        end else if (is_ld) begin
            exp_stall       = !(line_valid[idx] && line_tag[idx] == tag);
            exp_dat         = model_mem[midx];
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
        end
        check_word("load data column of the vector file", exp_dat, vec_exp[i]);
        b            = '0;
        b.valid      = 1'b1;
        b.alu_result = vec_addr[i];
        b.second_opr = vec_wdata[i];
        b.nx_pc      = 32'h0000_1000 + 4 * i;
        b.memrd      = is_ld;
        b.memwr      = is_st;
        b.rd         = vec_rd[i];
        b.mem2reg    = is_ld;
        b.regwr      = !is_st;
        exp_wb            = '0;
        exp_wb.valid      = 1'b1;
        exp_wb.nx_pc      = b.nx_pc;
        exp_wb.alu_result = b.alu_result;
        exp_wb.mem_dat    = exp_dat;
        exp_wb.rd         = b.rd;
        exp_wb.mem2reg    = b.mem2reg;
        exp_wb.regwr      = b.regwr;
        @(posedge clk);
        ex_mem <= b;
        saw_stall = 1'b0;
        // bundle held until a cycle without stall
        @(negedge clk);
        while (stall) begin
            saw_stall = 1'b1;
            // MEM/WB carries a bubble while the cache holds the bundle
            check_flag("mem_wb.valid", 1'b0, mem_wb.valid);
            @(negedge clk);
        end
        @(posedge clk);
        ex_mem <= '0;
        @(negedge clk);
        check_wb("mem_wb", exp_wb, mem_wb);
        check_flag("stall", exp_stall, saw_stall);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        ex_mem = '0;
        for (int k = 0; k < MODEL_WORDS; k++) begin
            model_mem[k] = word_t'(k);
        end
        for (int k = 0; k < LINES; k++) begin
            line_valid[k] = 1'b0;
            line_tag[k]   = '0;
        end
        read_vectors();
        // worst case is a refill per vector
        cycle_limit = vec_op.size() * CYC_PER_VEC + RST_CYCLES + 4;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("mem_wb.valid", 1'b0, mem_wb.valid);
        check_flag("mem_wb.regwr", 1'b0, mem_wb.regwr);
        check_flag("mem_wb.mem2reg", 1'b0, mem_wb.mem2reg);
        check_flag("stall", 1'b0, stall);
        for (int i = 0; i < vec_op.size(); i++) begin
            run_vector(i);
        end
        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
// backing word memory for the data cache, one word per four-phase req/ack transfer
`timescale 1ns/10ps
`default_nettype none

module data_ram
    import pipe_pkg::*;
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ram_req_t ram_req,
    output ram_rsp_t ram_rsp
);

    localparam int WORDS = 256;
    localparam int AW    = $clog2(WORDS);

    word_t         mem [WORDS];
    logic          ack_q;
    word_t         rdata_q;
    logic [AW-1:0] waddr;

    // upper address bits wrap
    assign waddr = ram_req.addr[AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            // each word starts out holding its own word address
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= word_t'(i);
            end
        end else begin
            if (ram_req.req && !ack_q) begin
                // phase 2, write lands with the rising ack
                ack_q <= 1'b1;
                if (ram_req.we) begin
                    mem[waddr] <= ram_req.wdata;
                end
            end else if (!ram_req.req && ack_q) begin
                // phase 4
                ack_q <= 1'b0;
            end
        end
    end

    // read data valid alongside ack
    always_ff @(posedge clk) begin
        if (ram_req.req && !ack_q) begin
            rdata_q <= mem[waddr];
        end
    end

    always_comb begin
        ram_rsp.ack   = ack_q;
        ram_rsp.rdata = rdata_q;
    end

    // requester holds req until it has seen the ack
    a_ack_has_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ram_rsp.ack) |-> ram_req.req
    );

endmodule

`default_nettype wire

//--- verilog/mem_subsys.sv
// top level of the memory subsystem, memory stage in front of the data cache and backing RAM
`timescale 1ns/10ps
`default_nettype none

module mem_subsys
    import pipe_pkg::*;
    import cache_pkg::*;
#(
    parameter int BIT_W = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output logic    stall
);

    // stage to cache
    dc_req_t  dc_req;
    word_t    dc_rdata;
    logic     dc_stall;
    // cache to RAM
    ram_req_t ram_req;
    ram_rsp_t ram_rsp;

    // upstream holds ex_mem while the cache is busy
    assign stall = dc_stall;

    mem_stage #(
        .BIT_W (BIT_W)
    ) u_mem_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .dc_req   (dc_req),
        .dc_rdata (dc_rdata),
        .dc_stall (dc_stall)
    );

    dcache u_dcache (
        .clk      (clk),
        .rst_n    (rst_n),
        .dc_req   (dc_req),
        .dc_rdata (dc_rdata),
        .dc_stall (dc_stall),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .ram_req (ram_req),
        .ram_rsp (ram_rsp)
    );

endmodule

`default_nettype wire
